/* fifo_async_asym.f */
common/afifo_pkg.sv
hw/gray_counter.sv
hw/gray_ptr_sync.sv
hw/ram_t2p_asym.sv
fifo_async_asym/fifo_level_tracker.sv
fifo_async_asym/fifo_async_asym.sv
sim/fifo_async_asym_assertions.sv
sim/tb_fifo_async_asym.sv

/* sim/tb_fifo_async_asym.sv */
`timescale 1ns/1ps

module tb_fifo_async_asym
   import afifo_pkg::*;
();

   localparam int R_PERIOD = 40;
   localparam int W_PERIOD = 56;
   localparam int RESET_CYCLES = 8;
   localparam int SETTLE_CYCLES = 8;
   localparam logic [31:0] SEED = 32'hb133_3d5b;

   // phase lengths, write bursts in w_clk cycles, read bursts in r_clk cycles
   localparam int FILL_W = 24;
   localparam int DRAIN_R = 80;
   localparam int EMPTY_TRY_R = 8;
   localparam int MIX_R = 1500;
   localparam int MIX_W = MIX_R * R_PERIOD / W_PERIOD;

   // the same phases counted in r_clk cycles
   localparam int SETTLE_R = ((SETTLE_CYCLES + 1) * W_PERIOD + R_PERIOD - 1) / R_PERIOD;
   localparam int FILL_LEN = (FILL_W * W_PERIOD + R_PERIOD - 1) / R_PERIOD + SETTLE_R;
   localparam int DRAIN_LEN = DRAIN_R + EMPTY_TRY_R + 2 * SETTLE_R;
   localparam int MIX_LEN = MIX_R + SETTLE_R;
   localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + FILL_LEN + DRAIN_LEN + MIX_LEN);

   logic r_clk;
   logic w_clk;
   logic reset;
   logic w_en;
   logic r_en;
   wdata_t w_data;
   rdata_t r_data;
   fifo_status_t w_status;
   fifo_status_t r_status;

   // reference model, one entry per byte
   rdata_t model_q[$];
   rdata_t exp_byte;
   logic rd_pending;
   int wr_count;
   int rd_count;

   int data_errors;
   int status_errors;
   int other_errors;
   int cycle_count;

   // separate random streams for the two clock domains
   logic [31:0] w_lfsr;
   logic [31:0] r_lfsr;

   initial begin
      r_clk = 1'b0;
      forever #(R_PERIOD / 2) r_clk = ~r_clk;
   end

   initial begin
      w_clk = 1'b0;
      forever #(W_PERIOD / 2) w_clk = ~w_clk;
   end

   fifo_async_asym i_dut (
      .r_clk(r_clk),
      .w_clk(w_clk),
      .reset(reset),
      .w_en(w_en),
      .w_data(w_data),
      .w_status(w_status),
      .r_en(r_en),
      .r_data(r_data),
      .r_status(r_status)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_next(state);
         value = {value[30:0], state[0]};
      end
   endtask

   task automatic compare_status(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      assert (got == exp) else begin
         status_errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic write_burst(input int n, input bit random_en);
      logic [31:0] bits;
      for (int i = 0; i < n; i++) begin
         @(negedge w_clk);
         if (random_en) begin
            // one write in four cycles
            take_bits(w_lfsr, 2, bits);
            w_en = &bits[1:0];
         end else begin
            w_en = 1'b1;
         end
         take_bits(w_lfsr, W_DATA_W, bits);
         w_data = bits;
      end
   endtask

   task automatic read_burst(input int n, input bit random_en);
      logic [31:0] bits;
      for (int i = 0; i < n; i++) begin
         @(negedge r_clk);
         if (random_en) begin
            // three reads in four cycles, close to the write byte rate
            take_bits(r_lfsr, 2, bits);
            r_en = |bits[1:0];
         end else begin
            r_en = 1'b1;
         end
      end
   endtask

   // both enables low, then a quiet period in each domain
   task automatic settle();
      fork
         begin
            @(negedge w_clk);
            w_en = 1'b0;
            repeat (SETTLE_CYCLES) @(negedge w_clk);
         end
         begin
            @(negedge r_clk);
            r_en = 1'b0;
            repeat (SETTLE_CYCLES) @(negedge r_clk);
         end
      join
   endtask

   task automatic check_reset_state();
      compare_status("w_status.level", w_status.level, 0);
      compare_status("w_status.empty", w_status.empty, 1);
      compare_status("w_status.full", w_status.full, 0);
      compare_status("r_status.level", r_status.level, 0);
      compare_status("r_status.empty", r_status.empty, 1);
      compare_status("r_status.full", r_status.full, 0);
      compare_status("r_data", r_data, 0);
   endtask

   // level and flags once both domains have seen every access
   task automatic check_settled();
      int exp_level;
      exp_level = W_INCR * wr_count - R_INCR * rd_count;
      compare_status("w_status.level", w_status.level, exp_level);
      compare_status("r_status.level", r_status.level, exp_level);
      compare_status("w_status.empty", w_status.empty, exp_level < R_INCR);
      compare_status("r_status.empty", r_status.empty, exp_level < R_INCR);
      compare_status("w_status.full", w_status.full, exp_level > FIFO_SIZE - W_INCR);
      compare_status("r_status.full", r_status.full, exp_level > FIFO_SIZE - W_INCR);
   endtask

   // reads against an empty fifo must leave pointer and data alone
   task automatic check_empty_reads();
      rptr_t ptr_before;
      rdata_t data_before;
      ptr_before = i_dut.r_bin;
      data_before = r_data;
      read_burst(EMPTY_TRY_R, 1'b0);
      settle();
      compare_status("i_dut.r_bin", i_dut.r_bin, ptr_before);
      compare_status("r_data", r_data, data_before);
      compare_status("r_status.empty", r_status.empty, 1);
   endtask

   task automatic report_counts();
      $display("error counts: data %0d, status %0d, other %0d",
               data_errors, status_errors, other_errors);
   endtask

   // four bytes per accepted write, lane 0 first
   always @(posedge w_clk) begin
      if (!reset && w_en && !w_status.full) begin
         for (int i = 0; i < RATIO; i++) begin
            model_q.push_back(w_data[i*R_DATA_W +: R_DATA_W]);
         end
         wr_count++;
      end
   end

   always @(posedge r_clk) begin
      if (!reset && r_en && !r_status.empty) begin
         rd_count++;
         assert (model_q.size() > 0) else begin
            other_errors++;
            $display("a read was accepted while the model holds no data");
         end
         if (model_q.size() > 0) begin
            exp_byte = model_q.pop_front();
            rd_pending = 1'b1;
         end
      end
   end

   // r_data is registered, so look at it half a cycle after the read edge
   always @(negedge r_clk) begin
      if (rd_pending) begin
         rd_pending = 1'b0;
         assert (r_data == exp_byte) else begin
            data_errors++;
            $display("FAILED r_data: got %h, expected %h", r_data, exp_byte);
         end
      end
   end

   always @(posedge r_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         other_errors++;
         $display("the test did not finish within %0d r_clk cycles", TIMEOUT_CYCLES);
         report_counts();
         $display("Verification failed");
         $finish;
      end
   end

   initial begin
      reset = 1'b1;
      w_en = 1'b0;
      r_en = 1'b0;
      w_data = '0;
      rd_pending = 1'b0;
      wr_count = 0;
      rd_count = 0;
      data_errors = 0;
      status_errors = 0;
      other_errors = 0;
      cycle_count = 0;
      w_lfsr = SEED;
      r_lfsr = SEED;

      repeat (RESET_CYCLES) @(negedge r_clk);
      reset = 1'b0;
      @(negedge r_clk);
      check_reset_state();

      // fill until full, keep pushing against it
      write_burst(FILL_W, 1'b0);
      settle();
      check_settled();
      compare_status("w_status.full", w_status.full, 1);
      compare_status("w_status.level", w_status.level, FIFO_SIZE);
      compare_status("wr_count", wr_count, FIFO_SIZE / W_INCR);
      compare_status("i_dut.w_bin", i_dut.w_bin, FIFO_SIZE / W_INCR);

      // drain until empty, keep pulling against it
      read_burst(DRAIN_R, 1'b0);
      settle();
      check_settled();
      compare_status("r_status.empty", r_status.empty, 1);
      compare_status("rd_count", rd_count, FIFO_SIZE);
      check_empty_reads();

      fork
         write_burst(MIX_W, 1'b1);
         read_burst(MIX_R, 1'b1);
      join
      settle();
      check_settled();

      report_counts();
      if (data_errors + status_errors + other_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* sim/fifo_async_asym_assertions.sv */
`timescale 1ns/1ps

module fifo_async_asym_assertions
   import afifo_pkg::*;
(
   input logic r_clk,
   input logic w_clk,
   input logic reset,
   input fifo_status_t w_status,
   input fifo_status_t r_status,
   input wptr_t w_gray,
   input rptr_t r_gray
);

   // a level of 0 and a level above 60 cannot coexist
   assert property (@(posedge w_clk) disable iff (reset) !(w_status.full && w_status.empty))
      else $error("write side shows full and empty together");
   assert property (@(posedge r_clk) disable iff (reset) !(r_status.full && r_status.empty))
      else $error("read side shows full and empty together");

   assert property (@(posedge w_clk) disable iff (reset) w_status.level <= FIFO_SIZE)
      else $error("write side level above capacity");
   assert property (@(posedge r_clk) disable iff (reset) r_status.level <= FIFO_SIZE)
      else $error("read side level above capacity");

   // single bit steps keep the synchronizers safe
   assert property (@(posedge w_clk) disable iff (reset) $countones(w_gray ^ $past(w_gray)) <= 1)
      else $error("write gray pointer changed more than one bit");
   assert property (@(posedge r_clk) disable iff (reset) $countones(r_gray ^ $past(r_gray)) <= 1)
      else $error("read gray pointer changed more than one bit");

endmodule

bind fifo_async_asym fifo_async_asym_assertions i_assertions (
   .r_clk(r_clk),
   .w_clk(w_clk),
   .reset(reset),
   .w_status(w_status),
   .r_status(r_status),
   .w_gray(w_gray),
   .r_gray(r_gray)
);

/* fifo_async_asym/fifo_async_asym.sv */
`timescale 1ns/1ps

module fifo_async_asym
   import afifo_pkg::*;
(
   input logic r_clk,
   input logic w_clk,
   input logic reset,

   // write side, w_clk domain
   input logic w_en,
   input wdata_t w_data,
   output fifo_status_t w_status,

   // read side, r_clk domain
   input logic r_en,
   output rdata_t r_data,
   output fifo_status_t r_status
);

   // accesses that actually happen
   logic w_acc;
   logic r_acc;

   // write pointer in its own domain
   wptr_t w_bin;
   wptr_t w_gray;
   wptr_t w_ahead;

   // read pointer in its own domain
   rptr_t r_bin;
   rptr_t r_gray;
   rptr_t r_ahead;

   // foreign pointers after synchronization
   wptr_t r_w_bin;
   rptr_t w_r_bin;

   // normalized pointers seen by each tracker
   rptr_t w_wr_ptr_n;
   rptr_t w_rd_ptr_n;
   rptr_t r_wr_ptr_n;
   rptr_t r_rd_ptr_n;

   // enables against a blocking flag are dropped here
   assign w_acc = w_en & ~w_status.full;
   assign r_acc = r_en & ~r_status.empty;

   gray_counter #(
      .W($bits(wptr_t))
   ) i_w_counter (
      .r_clk(w_clk),
      .reset(reset),
      .en(w_acc),
      .bin(w_bin),
      .gray(w_gray)
   );

   gray_counter #(
      .W($bits(rptr_t))
   ) i_r_counter (
      .r_clk(r_clk),
      .reset(reset),
      .en(r_acc),
      .bin(r_bin),
      .gray(r_gray)
   );

   // write pointer into the read domain
   gray_ptr_sync #(
      .W($bits(wptr_t))
   ) i_w2r_sync (
      .r_clk(r_clk),
      .reset(reset),
      .gray_in(w_gray),
      .bin_out(r_w_bin)
   );

   // read pointer into the write domain
   gray_ptr_sync #(
      .W($bits(rptr_t))
   ) i_r2w_sync (
      .r_clk(w_clk),
      .reset(reset),
      .gray_in(r_gray),
      .bin_out(w_r_bin)
   );

   // own pointer including this cycle's access, so the registered
   // status already counts it on the same edge as the counter
   assign w_ahead = w_bin + wptr_t'(w_acc);
   assign r_ahead = r_bin + rptr_t'(r_acc);

   // write pointer counts words, shift to byte units
   assign w_wr_ptr_n = {w_ahead, {LANE_W{1'b0}}};
   assign w_rd_ptr_n = w_r_bin;
   assign r_wr_ptr_n = {r_w_bin, {LANE_W{1'b0}}};
   assign r_rd_ptr_n = r_ahead;

   fifo_level_tracker i_w_tracker (
      .r_clk(w_clk),
      .reset(reset),
      .wr_ptr_n(w_wr_ptr_n),
      .rd_ptr_n(w_rd_ptr_n),
      .status(w_status)
   );

   fifo_level_tracker i_r_tracker (
      .r_clk(r_clk),
      .reset(reset),
      .wr_ptr_n(r_wr_ptr_n),
      .rd_ptr_n(r_rd_ptr_n),
      .status(r_status)
   );

   // wrap bits are left off the ram addresses
   ram_t2p_asym i_ram (
      .w_clk(w_clk),
      .w_en(w_acc),
      .w_addr(w_bin[W_ADDR_W-1:0]),
      .w_data(w_data),
      .r_clk(r_clk),
      .r_en(r_acc),
      .r_addr(r_bin[ADDR_W-1:0]),
      .r_data(r_data)
   );

endmodule

/* fifo_async_asym/fifo_level_tracker.sv */
`timescale 1ns/1ps

module fifo_level_tracker
   import afifo_pkg::*;
(
   input logic r_clk,
   input logic reset,

   // both pointers in read-word units
   input rptr_t wr_ptr_n,
   input rptr_t rd_ptr_n,

   output fifo_status_t status
);

   level_t level_nxt;
   fifo_status_t status_nxt;

   // modulo difference, the wrap bit keeps 0 and FIFO_SIZE apart
   assign level_nxt = level_t'(wr_ptr_n - rd_ptr_n);

   always_comb begin
      status_nxt.level = level_nxt;

      // not even one read word left
      status_nxt.empty = (level_nxt < level_t'(R_INCR));

      // less room than a whole write word
      status_nxt.full = (level_nxt > level_t'(FIFO_SIZE - W_INCR));
   end

   always_ff @(posedge r_clk) begin
      if (reset) begin
         status.level <= '0;
         status.empty <= 1'b1;
         status.full <= 1'b0;
      end else begin
         status <= status_nxt;
      end
   end

endmodule

/* hw/ram_t2p_asym.sv */
`timescale 1ns/1ps

module ram_t2p_asym
   import afifo_pkg::*;
(
   // wide write port
   input logic w_clk,
   input logic w_en,
   input logic [W_ADDR_W-1:0] w_addr,
   input wdata_t w_data,

   // narrow read port
   input logic r_clk,
   input logic r_en,
   input logic [ADDR_W-1:0] r_addr,
   output rdata_t r_data
);

   // 16 words of 32 bits
   wdata_t mem [2**W_ADDR_W];

   // byte address split into word and lane
   logic [W_ADDR_W-1:0] r_word;
   logic [LANE_W-1:0] r_lane;

   // output register powers up cleared
   rdata_t r_data_q = '0;

   always_ff @(posedge w_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   assign r_word = r_addr[ADDR_W-1:LANE_W];
   assign r_lane = r_addr[LANE_W-1:0];

   // lane 0 is the lowest byte of the stored word
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data_q <= mem[r_word][r_lane*R_DATA_W +: R_DATA_W];
      end
   end

   // holds the last byte until the next accepted read
   assign r_data = r_data_q;

endmodule

/* hw/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync #(
   parameter int W = 4
) (
   input logic r_clk,
   input logic reset,
   input logic [W-1:0] gray_in,
   output logic [W-1:0] bin_out
);

   // first stage may go metastable, second one settles it
   logic [W-1:0] meta_q;
   logic [W-1:0] sync_q;

   always_ff @(posedge r_clk) begin
      if (reset) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_in;
         sync_q <= meta_q;
      end
   end

   // gray to binary
   // each bit is the xor of all gray bits from the top down to it
   always_comb begin
      bin_out[W-1] = sync_q[W-1];
      for (int i = W - 2; i >= 0; i--) begin
         bin_out[i] = bin_out[i+1] ^ sync_q[i];
      end
   end

endmodule

/* hw/gray_counter.sv */
`timescale 1ns/1ps

module gray_counter #(
   parameter int W = 4
) (
   input logic r_clk,
   input logic reset,
   input logic en,
   output logic [W-1:0] bin,
   output logic [W-1:0] gray
);

   logic [W-1:0] bin_nxt;

   // count value after this cycle's increment
   assign bin_nxt = bin + {{(W-1){1'b0}}, en};

   // gray code comes straight from a flop, so it is glitch free
   // for the synchronizer on the other side
   always_ff @(posedge r_clk) begin
      if (reset) begin
         bin <= '0;
         gray <= '0;
      end else begin
         bin <= bin_nxt;
         gray <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

endmodule

/* common/afifo_pkg.sv */
package afifo_pkg;

   // word widths on each side
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // read words packed into one write word
   localparam int RATIO = W_DATA_W / R_DATA_W;

   // storage is addressed in read words (bytes)
   localparam int ADDR_W = 6;
   localparam int LANE_W = $clog2(RATIO);
   localparam int W_ADDR_W = ADDR_W - LANE_W;

   // capacity in read words
   localparam int FIFO_SIZE = 2 ** ADDR_W;

   // level change per access, in read words
   localparam int W_INCR = RATIO;
   localparam int R_INCR = 1;

   typedef logic [W_DATA_W-1:0] wdata_t;
   typedef logic [R_DATA_W-1:0] rdata_t;

   // pointers carry one wrap bit above the address
   typedef logic [W_ADDR_W:0] wptr_t;
   typedef logic [ADDR_W:0] rptr_t;

   // 0 to FIFO_SIZE inclusive, needs the extra bit
   typedef logic [ADDR_W:0] level_t;

   // one clock domain's view of the fifo
   typedef struct packed {
      level_t level;
      logic empty;
      logic full;
   } fifo_status_t;

endpackage
